//--- fpl_cluster.f
+incdir+design
design/fpl_pkg.sv
design/fpl_cvt_if.sv
design/fp_to_int.sv
design/fpl_lane.sv
design/fpl_cvt_arbiter.sv
design/fpl_cluster.sv
tb/tb_fpl_cluster.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fpl_cluster testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fpl_cluster.f \
  --top-module tb_fpl_cluster -o tb_fpl_cluster \
  && ./obj_dir/tb_fpl_cluster | tee /dev/stderr | grep -x "TEST RESULT: PASS" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/fpl_tests.txt
# group lane op(0 neg 1 abs 2 min 3 max 4 cvt 5 unused) a b expected_res expected_invalid name
# a, b and expected_res in hex, tests sharing a group are issued on the same edge
1 0 0 3f800000 00000000 bf800000 0 neg_one
1 1 1 c0490fdb 00000000 40490fdb 0 abs_neg_pi
1 2 0 7f800000 00000000 ff800000 0 neg_inf
2 0 0 7fc00001 00000000 ffc00001 0 neg_nan
2 1 1 ffc00000 00000000 7fc00000 0 abs_nan
2 2 0 80000000 00000000 00000000 0 neg_negzero
3 0 2 bf800000 3f800000 bf800000 0 min_mixed
3 1 3 bf800000 3f800000 3f800000 0 max_mixed
3 2 2 80000000 00000000 80000000 0 min_negzero
4 0 3 80000000 00000000 00000000 0 max_negzero
4 1 2 40000000 40000000 40000000 0 min_equal
4 2 3 7fc00000 3f800000 7fc00000 1 max_nan_a
5 0 2 3f800000 ff800001 7fc00000 1 min_nan_b
5 1 2 c0000000 c0400000 c0400000 0 min_both_neg
5 2 5 12345678 9abcdef0 12345678 1 unused_op
6 0 4 40490fdb 00000000 00000003 0 cvt_pi
7 2 4 c0490fdb 00000000 fffffffd 0 cvt_neg_pi
7 1 4 3f000000 00000000 00000000 0 cvt_half
8 0 4 cf000000 00000000 80000000 0 cvt_min_int
8 1 4 4f000000 00000000 7fffffff 1 cvt_pos_ovf
8 2 4 d0000000 00000000 80000000 1 cvt_neg_ovf
9 0 4 7fc00000 00000000 80000000 1 cvt_nan
9 1 4 c2f60000 00000000 ffffff85 0 cvt_neg_123
9 2 4 3fffffff 00000000 00000001 0 cvt_below_two
10 0 3 40400000 40000000 40400000 0 max_three_two
10 1 4 4b000001 00000000 00800001 0 cvt_large
10 2 4 4effffff 00000000 7fffff80 0 cvt_below_top
11 0 4 bf800000 00000000 ffffffff 0 cvt_neg_one
11 1 0 00000000 00000000 80000000 0 neg_poszero
11 2 4 c7000000 00000000 ffff8000 0 cvt_neg_32768

//--- tb/tb_fpl_cluster.sv
`timescale 1ns/1ps
`include "fpl_config.svh"

module tb_fpl_cluster;

  localparam int N           = `FPL_LANES;
  localparam int RET_TIMEOUT = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  lane_en  [N];
  fpl_pkg::fpl_op_e      lane_op  [N];
  logic [31:0]           lane_a   [N];
  logic [31:0]           lane_b   [N];
  logic [`FPL_TAG_W-1:0] lane_tag [N];
  logic                  ret_en   [N];
  logic [31:0]           res      [N];
  logic [`FPL_TAG_W-1:0] ret_tag  [N];
  logic                  invalid  [N];

  // vectors as read from the test file
  int          t_group [$];
  int          t_lane  [$];
  int          t_op    [$];
  logic [31:0] t_a     [$];
  logic [31:0] t_b     [$];
  logic [31:0] t_res   [$];
  int          t_inv   [$];
  string       t_name  [$];

  logic [`FPL_TAG_W-1:0] tag_cnt;
  integer                seed;

  fpl_cluster i_fpl_cluster (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_0_en      (lane_en[0]),
    .lane_0_op      (lane_op[0]),
    .lane_0_a       (lane_a[0]),
    .lane_0_b       (lane_b[0]),
    .lane_0_tag     (lane_tag[0]),
    .lane_0_ret_en  (ret_en[0]),
    .lane_0_res     (res[0]),
    .lane_0_ret_tag (ret_tag[0]),
    .lane_0_invalid (invalid[0]),
    .lane_1_en      (lane_en[1]),
    .lane_1_op      (lane_op[1]),
    .lane_1_a       (lane_a[1]),
    .lane_1_b       (lane_b[1]),
    .lane_1_tag     (lane_tag[1]),
    .lane_1_ret_en  (ret_en[1]),
    .lane_1_res     (res[1]),
    .lane_1_ret_tag (ret_tag[1]),
    .lane_1_invalid (invalid[1]),
    .lane_2_en      (lane_en[2]),
    .lane_2_op      (lane_op[2]),
    .lane_2_a       (lane_a[2]),
    .lane_2_b       (lane_b[2]),
    .lane_2_tag     (lane_tag[2]),
    .lane_2_ret_en  (ret_en[2]),
    .lane_2_res     (res[2]),
    .lane_2_ret_tag (ret_tag[2]),
    .lane_2_invalid (invalid[2])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_fail($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          cnt;
    string       line;
    int          grp;
    int          ln;
    int          op;
    int          inv;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    string       name;
    fd = $fopen("tb/fpl_tests.txt", "r");
    if (fd == 0) begin
      stop_with_fail("could not open tb/fpl_tests.txt");
    end
    while ($fgets(line, fd) > 0) begin
      // skip column notes and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%d %d %d %h %h %h %d %s", grp, ln, op, a, b, r, inv, name);
      if (cnt != 8) begin
        stop_with_fail($sformatf("malformed line in test file: %s", line));
      end
      t_group.push_back(grp);
      t_lane.push_back(ln);
      t_op.push_back(op);
      t_a.push_back(a);
      t_b.push_back(b);
      t_res.push_back(r);
      t_inv.push_back(inv);
      t_name.push_back(name);
    end
    $fclose(fd);
  endtask

  // checks that no lane returns anything for a number of cycles
  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      for (int l = 0; l < N; l++) begin
        check($sformatf("%s lane %0d ret_en", what, l), 32'd0, 32'(ret_en[l]));
      end
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    expect_quiet(8, "in_reset");
    rst_n = 1'b1;
    expect_quiet(2, "after_reset");
  endtask

  // issues tests first..last on one falling edge, then collects every return
  task automatic run_group(input int first, input int last);
    logic [`FPL_TAG_W-1:0] tag_sent [N];
    int                    idx      [N];
    bit                    issued   [N];
    bit                    returned [N];
    int                    pending;
    int                    cyc;
    int                    lat;
    int                    l;
    int                    t;
    pending = 0;
    for (int i = 0; i < N; i++) begin
      issued[i]   = 1'b0;
      returned[i] = 1'b0;
      idx[i]      = 0;
      tag_sent[i] = '0;
    end
    for (int k = first; k <= last; k++) begin
      l = t_lane[k];
      if (l < 0 || l >= N || issued[l]) begin
        stop_with_fail($sformatf("test %s names a bad or repeated lane", t_name[k]));
      end
      issued[l]   = 1'b1;
      idx[l]      = k;
      tag_sent[l] = tag_cnt;
      pending++;
      lane_en[l]  = 1'b1;
      lane_op[l]  = fpl_pkg::fpl_op_e'(3'(t_op[k]));
      lane_a[l]   = t_a[k];
      lane_b[l]   = t_b[k];
      lane_tag[l] = tag_cnt;
      tag_cnt     = tag_cnt + 1'b1;
    end
    cyc = 0;
    while (pending > 0) begin
      @(negedge clk);
      cyc++;
      for (int i = 0; i < N; i++) begin
        lane_en[i] = 1'b0;
      end
      for (int i = 0; i < N; i++) begin
        if (ret_en[i] === 1'b1) begin
          if (!issued[i] || returned[i]) begin
            stop_with_fail($sformatf("lane %0d returned a result nobody was waiting for", i));
          end
          returned[i] = 1'b1;
          pending--;
          t   = idx[i];
          lat = cyc - 1;
          check({t_name[t], " res"}, t_res[t], res[i]);
          check({t_name[t], " invalid"}, 32'(t_inv[t]), 32'(invalid[i]));
          check({t_name[t], " tag"}, 32'(tag_sent[i]), 32'(ret_tag[i]));
          if (t_op[t] == int'(fpl_pkg::op_cvt)) begin
            // 4 cycles alone, up to 2 more behind the other lanes
            if (lat < 4 || lat > 6) begin
              stop_with_fail($sformatf("FAILED %s latency expected 4 to 6 actual %0d",
                                       t_name[t], lat));
            end
          end else begin
            check({t_name[t], " latency"}, 32'd1, 32'(lat));
          end
        end
      end
      if (pending > 0 && cyc >= RET_TIMEOUT) begin
        for (int i = 0; i < N; i++) begin
          if (issued[i] && !returned[i]) begin
            stop_with_fail($sformatf("lane %0d never returned within %0d cycles",
                                     i, RET_TIMEOUT));
          end
        end
      end
    end
  endtask

  initial begin
    int first;
    int last;
    int gap;
    seed    = 80082;
    tag_cnt = '0;
    rst_n   = 1'b0;
    for (int l = 0; l < N; l++) begin
      lane_en[l]  = 1'b0;
      lane_op[l]  = fpl_pkg::op_neg;
      lane_a[l]   = '0;
      lane_b[l]   = '0;
      lane_tag[l] = '0;
    end
    load_tests();
    apply_reset();
    first = 0;
    while (first < t_group.size()) begin
      last = first;
      while (last + 1 < t_group.size() && t_group[last + 1] == t_group[first]) begin
        last++;
      end
      run_group(first, last);
      gap = int'($unsigned($random(seed)) % 4);
      expect_quiet(gap, "idle");
      first = last + 1;
    end
    if (t_group.size() == 0) begin
      stop_with_fail("the test file holds no vectors");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- design/fpl_cluster.sv
`timescale 1ns/1ps
`include "fpl_config.svh"

module fpl_cluster (
  input  logic                  clk,
  input  logic                  rst_n,
  // lane 0
  input  logic                  lane_0_en,
  input  fpl_pkg::fpl_op_e      lane_0_op,
  input  logic [31:0]           lane_0_a,
  input  logic [31:0]           lane_0_b,
  input  logic [`FPL_TAG_W-1:0] lane_0_tag,
  output logic                  lane_0_ret_en,
  output logic [31:0]           lane_0_res,
  output logic [`FPL_TAG_W-1:0] lane_0_ret_tag,
  output logic                  lane_0_invalid,
  // lane 1
  input  logic                  lane_1_en,
  input  fpl_pkg::fpl_op_e      lane_1_op,
  input  logic [31:0]           lane_1_a,
  input  logic [31:0]           lane_1_b,
  input  logic [`FPL_TAG_W-1:0] lane_1_tag,
  output logic                  lane_1_ret_en,
  output logic [31:0]           lane_1_res,
  output logic [`FPL_TAG_W-1:0] lane_1_ret_tag,
  output logic                  lane_1_invalid,
  // lane 2
  input  logic                  lane_2_en,
  input  fpl_pkg::fpl_op_e      lane_2_op,
  input  logic [31:0]           lane_2_a,
  input  logic [31:0]           lane_2_b,
  input  logic [`FPL_TAG_W-1:0] lane_2_tag,
  output logic                  lane_2_ret_en,
  output logic [31:0]           lane_2_res,
  output logic [`FPL_TAG_W-1:0] lane_2_ret_tag,
  output logic                  lane_2_invalid
);

  fpl_pkg::fpl_word_u cvt_in_word;
  logic               cvt_in_valid;
  logic               cvt_out_valid;
  logic [31:0]        cvt_out_int;
  logic               cvt_out_invalid;

  // one request channel per lane into the arbiter
  fpl_cvt_if cvt_if [`FPL_LANES] ();

  fpl_lane i_lane_0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (lane_0_en),
    .op      (lane_0_op),
    .a       (lane_0_a),
    .b       (lane_0_b),
    .tag     (lane_0_tag),
    .cvt     (cvt_if[0]),
    .ret_en  (lane_0_ret_en),
    .res     (lane_0_res),
    .ret_tag (lane_0_ret_tag),
    .invalid (lane_0_invalid)
  );

  fpl_lane i_lane_1 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (lane_1_en),
    .op      (lane_1_op),
    .a       (lane_1_a),
    .b       (lane_1_b),
    .tag     (lane_1_tag),
    .cvt     (cvt_if[1]),
    .ret_en  (lane_1_ret_en),
    .res     (lane_1_res),
    .ret_tag (lane_1_ret_tag),
    .invalid (lane_1_invalid)
  );

  fpl_lane i_lane_2 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (lane_2_en),
    .op      (lane_2_op),
    .a       (lane_2_a),
    .b       (lane_2_b),
    .tag     (lane_2_tag),
    .cvt     (cvt_if[2]),
    .ret_en  (lane_2_ret_en),
    .res     (lane_2_res),
    .ret_tag (lane_2_ret_tag),
    .invalid (lane_2_invalid)
  );

  fpl_cvt_arbiter i_cvt_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .lanes       (cvt_if),
    .in_valid    (cvt_in_valid),
    .in_word     (cvt_in_word),
    .out_valid   (cvt_out_valid),
    .out_int     (cvt_out_int),
    .out_invalid (cvt_out_invalid)
  );

  // shared by all lanes
  fp_to_int i_fp_to_int (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (cvt_in_valid),
    .in_word     (cvt_in_word),
    .out_valid   (cvt_out_valid),
    .out_int     (cvt_out_int),
    .out_invalid (cvt_out_invalid)
  );

endmodule

//--- design/fpl_cvt_arbiter.sv
`timescale 1ns/1ps
`include "fpl_config.svh"

module fpl_cvt_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  fpl_cvt_if.arb             lanes [`FPL_LANES],
  output logic               in_valid,
  output fpl_pkg::fpl_word_u in_word,
  input  logic               out_valid,
  input  logic [31:0]        out_int,
  input  logic               out_invalid
);

  localparam int IDX_W = $clog2(`FPL_LANES);

  logic [`FPL_LANES-1:0] req;
  logic [`FPL_LANES-1:0] grant;
  fpl_pkg::fpl_word_u    operand [`FPL_LANES];
  // lane with first claim in the next cycle
  logic [IDX_W-1:0]      ptr;
  logic [IDX_W-1:0]      gidx;
  // owner of each conversion in flight
  logic [IDX_W-1:0]      idx_s1;
  logic [IDX_W-1:0]      idx_s2;

  for (genvar i = 0; i < `FPL_LANES; i++) begin : g_lane
    assign req[i]           = lanes[i].req;
    assign operand[i]       = lanes[i].operand;
    assign lanes[i].grant   = grant[i];
    assign lanes[i].done    = out_valid && (idx_s2 == IDX_W'(i));
    assign lanes[i].result  = out_int;
    assign lanes[i].invalid = out_invalid;
  end

  // scan from ptr upward with wrap, lowest offset wins
  always_comb begin
    int cand;
    grant = '0;
    gidx  = '0;
    for (int off = `FPL_LANES - 1; off >= 0; off--) begin
      cand = int'(ptr) + off;
      if (cand >= `FPL_LANES) begin
        cand = cand - `FPL_LANES;
      end
      if (req[IDX_W'(cand)]) begin
        gidx = IDX_W'(cand);
      end
    end
    if (req != '0) begin
      grant[gidx] = 1'b1;
    end
  end

  assign in_valid = |req;
  assign in_word  = operand[gidx];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (in_valid) begin
      ptr <= (gidx == IDX_W'(`FPL_LANES - 1)) ? '0 : gidx + IDX_W'(1);
    end
  end

  // index shifts in step with the two converter stages
  always_ff @(posedge clk) begin
    idx_s1 <= gidx;
    idx_s2 <= idx_s1;
  end

  // a request held while every other lane had its turn is served now
  for (genvar i = 0; i < `FPL_LANES; i++) begin : g_fair
    a_grant_fair: assert property (@(posedge clk) disable iff (!rst_n)
      req[i] && $past(req[i], `FPL_LANES - 1) |-> grant[i])
      else $error("conversion request passed over by the round robin");
  end

  a_cvt_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##2 out_valid)
    else $error("converter result missing two cycles after capture");

  a_cvt_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, 2))
    else $error("converter result without a capture");

endmodule

//--- design/fpl_lane.sv
`timescale 1ns/1ps
`include "fpl_config.svh"

module fpl_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  fpl_pkg::fpl_op_e      op,
  input  fpl_pkg::fpl_word_u    a,
  input  fpl_pkg::fpl_word_u    b,
  input  logic [`FPL_TAG_W-1:0] tag,
  fpl_cvt_if.lane               cvt,
  output logic                  ret_en,
  output logic [31:0]           res,
  output logic [`FPL_TAG_W-1:0] ret_tag,
  output logic                  invalid
);

  // issue stage, the payload stays put until the lane returns
  logic                  s1_vld;
  fpl_pkg::fpl_op_e      s1_op;
  fpl_pkg::fpl_word_u    s1_a;
  fpl_pkg::fpl_word_u    s1_b;
  logic [`FPL_TAG_W-1:0] s1_tag;

  // conversion progress
  logic                  req;
  logic                  wait_done;
  logic                  busy;

  fpl_pkg::fpl_word_u    loc_res;
  logic                  loc_inv;
  logic                  loc_ret;
  logic                  a_nan;
  logic                  b_nan;
  logic                  a_lt_b;

  assign busy    = s1_vld | req | wait_done;
  assign loc_ret = s1_vld && (s1_op != fpl_pkg::op_cvt);

  always_ff @(posedge clk) begin
    if (en) begin
      s1_op  <= op;
      s1_a   <= a;
      s1_b   <= b;
      s1_tag <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      req       <= 1'b0;
      wait_done <= 1'b0;
    end else begin
      s1_vld <= en;
      if (s1_vld && s1_op == fpl_pkg::op_cvt) begin
        req <= 1'b1;
      end else if (cvt.grant) begin
        req <= 1'b0;
      end
      if (req && cvt.grant) begin
        wait_done <= 1'b1;
      end else if (cvt.done) begin
        wait_done <= 1'b0;
      end
    end
  end

  // ordering on sign and raw magnitude, -0 sorts below +0
  always_comb begin
    a_nan = (s1_a.f.exp == 8'hff) && (s1_a.f.frac != '0);
    b_nan = (s1_b.f.exp == 8'hff) && (s1_b.f.frac != '0);
    if (s1_a.f.sign != s1_b.f.sign) begin
      a_lt_b = s1_a.f.sign;
    end else if (s1_a.f.sign) begin
      a_lt_b = s1_a.raw[30:0] > s1_b.raw[30:0];
    end else begin
      a_lt_b = s1_a.raw[30:0] < s1_b.raw[30:0];
    end
  end

  always_comb begin
    loc_res = s1_a;
    loc_inv = 1'b0;
    case (s1_op)
      fpl_pkg::op_neg: loc_res.f.sign = ~s1_a.f.sign;
      fpl_pkg::op_abs: loc_res.f.sign = 1'b0;
      fpl_pkg::op_min, fpl_pkg::op_max: begin
        if (a_nan || b_nan) begin
          loc_res.raw = `FPL_QNAN;
          loc_inv     = 1'b1;
        end else if (a_lt_b == (s1_op == fpl_pkg::op_max)) begin
          // min keeps b unless a is lower, max keeps b when a is lower
          loc_res = s1_b;
        end
      end
      default: loc_inv = 1'b1;
    endcase
  end

  assign cvt.req     = req;
  assign cvt.operand = s1_a;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ret_en <= 1'b0;
    end else begin
      ret_en <= loc_ret | cvt.done;
    end
  end

  always_ff @(posedge clk) begin
    ret_tag <= s1_tag;
    if (cvt.done) begin
      res     <= cvt.result;
      invalid <= cvt.invalid;
    end else begin
      res     <= loc_res.raw;
      invalid <= loc_inv;
    end
  end

  // no new strobe before the last result has been returned
  a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n) en |-> !busy)
    else $error("lane strobed while busy");

  // the arbiter only answers a lane it has granted
  a_done_owned: assert property (@(posedge clk) disable iff (!rst_n) cvt.done |-> wait_done)
    else $error("conversion done without a granted request");

endmodule

//--- design/fp_to_int.sv
`timescale 1ns/1ps

module fp_to_int (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  fpl_pkg::fpl_word_u in_word,
  output logic               out_valid,
  output logic [31:0]        out_int,
  output logic               out_invalid
);

  // biased exponents of 1.0 and 2^31
  localparam logic [7:0] EXP_ONE = 8'd127;
  localparam logic [7:0] EXP_TOP = 8'd158;

  logic        c_nan;
  logic        c_ovf;
  logic [4:0]  c_rsh;
  logic [31:0] c_mag;

  logic        s1_vld;
  logic        s1_sign;
  logic        s1_nan;
  logic        s1_ovf;
  logic [31:0] s1_mag;

  // stage one, classify and align
  always_comb begin
    c_nan = (in_word.f.exp == 8'hff) && (in_word.f.frac != '0);
    // exactly -2^31 still fits
    c_ovf = (in_word.f.exp > EXP_TOP) ||
            ((in_word.f.exp == EXP_TOP) && !(in_word.f.sign && in_word.f.frac == '0));
    c_rsh = 5'(EXP_TOP - in_word.f.exp);
    if (in_word.f.exp < EXP_ONE) begin
      c_mag = '0;
    end else begin
      // hidden bit at bit 31 stands for 2^31, shift down to the integer part
      c_mag = {1'b1, in_word.f.frac, 8'h00} >> c_rsh;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_vld    <= in_valid;
      out_valid <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_sign <= in_word.f.sign;
      s1_nan  <= c_nan;
      s1_ovf  <= c_ovf;
      s1_mag  <= c_mag;
    end
  end

  // stage two, sign and saturation
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      out_invalid <= s1_nan | s1_ovf;
      if (s1_nan) begin
        out_int <= 32'h8000_0000;
      end else if (s1_ovf) begin
        out_int <= s1_sign ? 32'h8000_0000 : 32'h7fff_ffff;
      end else begin
        out_int <= s1_sign ? -s1_mag : s1_mag;
      end
    end
  end

endmodule

//--- design/fpl_cvt_if.sv
`timescale 1ns/1ps

// conversion request and reply between one lane and the arbiter
interface fpl_cvt_if;

  // level, held by the lane until grant
  logic               req;
  fpl_pkg::fpl_word_u operand;
  // one-cycle pulses from the arbiter
  logic               grant;
  logic               done;
  // valid only while done is high
  logic [31:0]        result;
  logic               invalid;

  modport lane (
    output req,
    output operand,
    input  grant,
    input  done,
    input  result,
    input  invalid
  );

  modport arb (
    input  req,
    input  operand,
    output grant,
    output done,
    output result,
    output invalid
  );

endinterface

//--- design/fpl_pkg.sv
package fpl_pkg;

  // lane operation codes
  // codes 5 to 7 are unused and return operand a flagged invalid
  typedef enum logic [2:0] {
    op_neg = 3'd0,
    op_abs = 3'd1,
    op_min = 3'd2,
    op_max = 3'd3,
    op_cvt = 3'd4
  } fpl_op_e;

  // single precision operand word
  // the fields view serves sign handling and conversion,
  // the raw view serves the ordered magnitude compare
  typedef union packed {
    struct packed {
      logic        sign;
      // biased by 127
      logic [7:0]  exp;
      logic [22:0] frac;
    } f;
    logic [31:0] raw;
  } fpl_word_u;

endpackage

//--- design/fpl_config.svh
`ifndef FPL_CONFIG_SVH
`define FPL_CONFIG_SVH

// issue lanes sharing one converter
`define FPL_LANES 3

// width of the tag that travels with each operation
`define FPL_TAG_W 4

// canonical quiet nan, returned by min and max on a nan operand
`define FPL_QNAN 32'h7fc0_0000

`endif
